// File: hw/segDisplay_defines.svh
`ifndef SEG_DISPLAY_DEFINES_SVH
`define SEG_DISPLAY_DEFINES_SVH

// digit count, one 9-pin port per digit wired straight to IO
`define SEG_NUM 4

// cycles per scan slot (at most 16 for the 4-bit slot position)
`define SEG_SLOT 16

// full scan rounds per blink half-period
`define SEG_BLINK_ROUNDS 2

// common terminal polarity
// 1 for common anode, every pin level flipped
`define SEG_COM 1

`endif

// File: hw/segDisplay_pkg.sv
`include "segDisplay_defines.svh"

package segDisplay_pkg;

  // one digit register entry
  typedef struct packed {
    logic [4:0] code;  // 0..15 hex, 16..25 extended glyphs
    logic       dp;    // decimal point on
    logic       blink; // follows the blink phase
  } digitEntryT;

  // display configuration
  typedef struct packed {
    logic [3:0] level;  // brightness, cycles lit per slot
    logic       enable; // scan running
  } dispCfgT;

  // pin levels of one digit port, bit 8 dig, bit 7 dp, bits 6..0 g..a
  typedef struct packed {
    logic       dig;
    logic       dp;
    logic [6:0] seg;
  } segPortT;

  // digit select
  typedef logic [$clog2(`SEG_NUM)-1:0] digitIdxT;

endpackage

// File: hw/strobeBank.sv
`timescale 1ns/1ns
`include "segDisplay_defines.svh"

// register bank loaded by a plain write strobe
module strobeBank #(
  parameter type entryT = segDisplay_pkg::digitEntryT,
  parameter int  depth  = `SEG_NUM,
  localparam int idxW   = (depth > 1) ? $clog2(depth) : 1
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic            wr,     // strobe, one write per cycle max
  input  logic [idxW-1:0] idx,    // entry select
  input  entryT           wrData,
  output entryT           q [depth]
);

  // all entries come up zeroed
  // code 0, no dp, no blink / level 0, disabled
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < depth; i++) begin
        q[i] <= '0;
      end
    end else if (wr) begin
      for (int i = 0; i < depth; i++) begin
        if (idx == idxW'(i)) begin // only the addressed entry loads
          q[i] <= wrData;
        end
      end
    end
  end

endmodule

// File: hw/scanCtrl.sv
`timescale 1ns/1ns
`include "segDisplay_defines.svh"

// scan sequencer
// slot counter -> digit counter -> round counter -> blink phase
module scanCtrl (
  input  logic                     clk,
  input  logic                     arstN,
  input  segDisplay_pkg::dispCfgT  cfg,
  output segDisplay_pkg::digitIdxT curIdx,  // digit owning the current slot
  output logic [3:0]               slotPos, // cycle inside the slot
  output logic                     blinkOn  // blink phase, 1 = lit
);
  import segDisplay_pkg::*;

  localparam int roundW = (`SEG_BLINK_ROUNDS > 1) ? $clog2(`SEG_BLINK_ROUNDS) : 1;
  localparam logic [3:0] slotLast = 4'(`SEG_SLOT - 1);
  localparam digitIdxT idxLast = digitIdxT'(`SEG_NUM - 1);
  localparam logic [roundW-1:0] roundLast = roundW'(`SEG_BLINK_ROUNDS - 1);

  logic [roundW-1:0] roundCnt; // completed rounds in this blink phase
  logic              slotEnd;  // last cycle of a slot
  logic              roundEnd; // last cycle of the last digit's slot

  assign slotEnd  = (slotPos == slotLast);
  assign roundEnd = slotEnd && (curIdx == idxLast);

  // slot and digit counters
  // parked at zero while disabled, so the cycle enable rises is digit 0 slot 0
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      slotPos <= '0;
      curIdx  <= '0;
    end else if (!cfg.enable) begin
      slotPos <= '0;
      curIdx  <= '0;
    end else if (slotEnd) begin
      slotPos <= '0;
      curIdx  <= (curIdx == idxLast) ? '0 : curIdx + 1'b1; // wrap after last digit
    end else begin
      slotPos <= slotPos + 4'd1;
    end
  end

  // blink phase, flips every SEG_BLINK_ROUNDS full rounds
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      roundCnt <= '0;
      blinkOn  <= 1'b1;
    end else if (!cfg.enable) begin
      roundCnt <= '0;
      blinkOn  <= 1'b1; // restart lit
    end else if (roundEnd) begin
      if (roundCnt == roundLast) begin
        roundCnt <= '0;
        blinkOn  <= ~blinkOn;
      end else begin
        roundCnt <= roundCnt + 1'b1;
      end
    end
  end

endmodule

// File: hw/brightPwm.sv
`timescale 1ns/1ns
`include "segDisplay_defines.svh"

// per-digit enable
// scan select gated by brightness duty and blink phase
module brightPwm (
  input  logic                       clk,
  input  logic                       arstN,
  input  segDisplay_pkg::dispCfgT    cfg,
  input  segDisplay_pkg::digitEntryT entries [`SEG_NUM],
  input  segDisplay_pkg::digitIdxT   curIdx,
  input  logic [3:0]                 slotPos,
  input  logic                       blinkOn,
  output logic                       digEn   [`SEG_NUM] // logical, before polarity
);
  import segDisplay_pkg::*;

  logic inDuty; // still under the brightness level in this slot

  // level 0 never lit, level 15 lit 15 of 16 cycles
  assign inDuty = cfg.enable && (slotPos < cfg.level);

  generate
    for (genvar d = 0; d < `SEG_NUM; d++) begin : genEn
      logic sel;   // this digit owns the slot
      logic shown; // not masked by blink off phase

      assign sel   = (curIdx == digitIdxT'(d));
      assign shown = blinkOn || !entries[d].blink;

      // registered, lags curIdx by one cycle
      always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
          digEn[d] <= 1'b0;
        end else begin
          digEn[d] <= inDuty && sel && shown;
        end
      end
    end
  endgenerate

endmodule

// File: hw/segDecoder.sv
`timescale 1ns/1ns
`include "segDisplay_defines.svh"

// glyph decode and pin polarity for every digit port
module segDecoder (
  input  segDisplay_pkg::digitEntryT entries [`SEG_NUM],
  input  logic                       digEn   [`SEG_NUM],
  output segDisplay_pkg::segPortT    ledsd   [`SEG_NUM]
);

  localparam logic comLvl = 1'(`SEG_COM); // 1 flips every pin

  generate
    for (genvar i = 0; i < `SEG_NUM; i++) begin : genPort
      logic [6:0] glyph; // logical segments, g..a, 1 = lit

      always_comb begin
        case (entries[i].code)
          5'd0:    glyph = 7'h3F; // 0
          5'd1:    glyph = 7'h06; // 1
          5'd2:    glyph = 7'h5B; // 2
          5'd3:    glyph = 7'h4F; // 3
          5'd4:    glyph = 7'h66; // 4
          5'd5:    glyph = 7'h6D; // 5
          5'd6:    glyph = 7'h7D; // 6
          5'd7:    glyph = 7'h07; // 7
          5'd8:    glyph = 7'h7F; // 8
          5'd9:    glyph = 7'h6F; // 9
          5'd10:   glyph = 7'h77; // A
          5'd11:   glyph = 7'h7C; // b
          5'd12:   glyph = 7'h39; // C
          5'd13:   glyph = 7'h5E; // d
          5'd14:   glyph = 7'h79; // E
          5'd15:   glyph = 7'h71; // F
          // extended set, always on
          5'd16:   glyph = 7'h76; // H
          5'd17:   glyph = 7'h38; // L
          5'd18:   glyph = 7'h54; // n
          5'd19:   glyph = 7'h5C; // o
          5'd20:   glyph = 7'h73; // P
          5'd21:   glyph = 7'h67; // q
          5'd22:   glyph = 7'h3E; // U
          5'd23:   glyph = 7'h6E; // y
          5'd24:   glyph = 7'h40; // -
          5'd25:   glyph = 7'h48; // =
          default: glyph = 7'h00; // 26..31 dark
        endcase
      end

      // pin = logical XOR common level
      assign ledsd[i] = '{
        dig: digEn[i] ^ comLvl,
        dp:  entries[i].dp ^ comLvl,
        seg: glyph ^ {7{comLvl}}
      };
    end
  endgenerate

endmodule

// File: hw/segDisplayTop.sv
`timescale 1ns/1ns
`include "segDisplay_defines.svh"

// direct-drive seven-segment display, one 9-pin port per digit
module segDisplayTop (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic                       wrEn,    // digit entry write strobe
  input  segDisplay_pkg::digitIdxT   wrIdx,
  input  segDisplay_pkg::digitEntryT wrData,
  input  logic                       cfgWr,   // config write strobe
  input  segDisplay_pkg::dispCfgT    cfgData,
  output segDisplay_pkg::segPortT    ledsd [`SEG_NUM]
);
  import segDisplay_pkg::*;

  digitEntryT entries [`SEG_NUM]; // per-digit code, dp, blink
  dispCfgT    cfgQ    [1];        // single config entry
  digitIdxT   curIdx;
  logic [3:0] slotPos;
  logic       blinkOn;
  logic       digEn   [`SEG_NUM];

  strobeBank #(.entryT(digitEntryT), .depth(`SEG_NUM)) digitBank_i (
    .clk(clk), .arstN(arstN), .wr(wrEn), .idx(wrIdx), .wrData(wrData), .q(entries)
  );

  // one entry, index tied off
  strobeBank #(.entryT(dispCfgT), .depth(1)) cfgBank_i (
    .clk(clk), .arstN(arstN), .wr(cfgWr), .idx(1'b0), .wrData(cfgData), .q(cfgQ)
  );

  scanCtrl scanCtrl_i (
    .clk(clk), .arstN(arstN), .cfg(cfgQ[0]),
    .curIdx(curIdx), .slotPos(slotPos), .blinkOn(blinkOn)
  );

  brightPwm brightPwm_i (
    .clk(clk), .arstN(arstN), .cfg(cfgQ[0]), .entries(entries),
    .curIdx(curIdx), .slotPos(slotPos), .blinkOn(blinkOn), .digEn(digEn)
  );

  segDecoder segDecoder_i (.entries(entries), .digEn(digEn), .ledsd(ledsd));

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ns

// free-running testbench clock
module tbClock #(
  parameter int halfPeriod = 4 // 8 ns period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

endmodule

// File: tb/segDisplay_properties.sv
`timescale 1ns/1ns
`include "segDisplay_defines.svh"

// pin port and scan checks, bound into the top level
module segDisplay_properties (
  input logic                     clk,
  input logic                     arstN,
  input segDisplay_pkg::dispCfgT  cfg,
  input segDisplay_pkg::digitIdxT curIdx,
  input segDisplay_pkg::segPortT  ledsd [`SEG_NUM]
);
  import segDisplay_pkg::*;

  localparam logic comLvl = 1'(`SEG_COM);

  logic [`SEG_NUM-1:0] digActive; // logical dig level per port

  always_comb begin
    for (int d = 0; d < `SEG_NUM; d++) begin
      digActive[d] = ledsd[d].dig ^ comLvl;
    end
  end

  // direct drive, only one common terminal at a time
  oneDigit: assert property (@(posedge clk) disable iff (!arstN) $onehot0(digActive))
    else $error("more than one dig pin active");

  // digEn is registered, so it follows enable one cycle later
  darkWhenOff: assert property (@(posedge clk) disable iff (!arstN)
    !$past(cfg.enable) |-> (digActive == '0))
    else $error("dig pin active while the scan is disabled");

  // while scanning the index moves one digit at a time, wrapping below SEG_NUM
  idxStep: assert property (@(posedge clk) disable iff (!arstN)
    ($past(cfg.enable) && (curIdx != $past(curIdx)))
      |-> (int'(curIdx) == (int'($past(curIdx)) + 1) % `SEG_NUM))
    else $error("scan index skipped a digit or left the digit range");

endmodule

bind segDisplayTop segDisplay_properties props_i (
  .clk(clk), .arstN(arstN), .cfg(cfgQ[0]), .curIdx(curIdx), .ledsd(ledsd)
);

// File: tb/segDisplayTb.sv
`timescale 1ns/1ns
`include "segDisplay_defines.svh"

module segDisplayTb;
  import segDisplay_pkg::*;

  localparam logic comLvl = 1'(`SEG_COM);
  localparam int roundCycles = `SEG_NUM * `SEG_SLOT; // one full scan round
  localparam int blinkRounds = 2 * `SEG_BLINK_ROUNDS; // one whole blink period
  // per test cycle budget, reset through disable, plus margin
  localparam int budgetCycles = 4 + 32 * 4 + (4 * roundCycles + 8)
    + 5 * (roundCycles + 8) + (blinkRounds * roundCycles + 16)
    + (roundCycles + 16) + 200;

  logic       clk;
  logic       arstN;
  logic       wrEn;
  digitIdxT   wrIdx;
  digitEntryT wrData;
  logic       cfgWr;
  dispCfgT    cfgData;
  segPortT    ledsd [`SEG_NUM];

  digitEntryT  model [`SEG_NUM]; // expected register contents
  int          activeCnt [`SEG_NUM];
  logic [31:0] lfsrState;

  tbClock clkGen_i (.clk(clk));

  segDisplayTop dut_i (
    .clk(clk), .arstN(arstN), .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
    .cfgWr(cfgWr), .cfgData(cfgData), .ledsd(ledsd)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState); // one step per bit
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  // lit segments by letter, a is bit 0
  function automatic string glyphLetters(input int code);
    case (code)
      0: return "abcdef";
      1: return "bc";
      2: return "abdeg";
      3: return "abcdg";
      4: return "bcfg";
      5: return "acdfg";
      6: return "acdefg";
      7: return "abc";
      8: return "abcdefg";
      9: return "abcdfg";
      10: return "abcefg"; // A
      11: return "cdefg";  // b
      12: return "adef";   // C
      13: return "bcdeg";  // d
      14: return "adefg";  // E
      15: return "aefg";   // F
      16: return "bcefg";  // H
      17: return "def";    // L
      18: return "ceg";    // n
      19: return "cdeg";   // o
      20: return "abefg";  // P
      21: return "abcfg";  // q
      22: return "bcdef";  // U
      23: return "bcdfg";  // y
      24: return "g";      // -
      25: return "dg";     // =
      default: return "";  // dark
    endcase
  endfunction

  function automatic logic [6:0] glyphBits(input int code);
    string      letters;
    logic [6:0] g;
    logic [2:0] bitIdx;
    letters = glyphLetters(code);
    g = '0;
    for (int i = 0; i < letters.len(); i++) begin
      bitIdx = 3'(int'(letters.getc(i)) - 97);
      g[bitIdx] = 1'b1;
    end
    return g;
  endfunction

  function automatic segPortT expectedPort(input digitEntryT e, input logic active);
    segPortT p;
    p.dig = active ^ comLvl;
    p.dp  = e.dp ^ comLvl;
    p.seg = glyphBits(int'(e.code)) ^ {7{comLvl}};
    return p;
  endfunction

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkPort(input string testName, input segPortT expected,
                           input segPortT actual);
    if (actual !== expected) begin
      failNow($sformatf("Fail %s: expected %h, actual %h", testName, expected, actual));
    end
  endtask

  task automatic checkCount(input string testName, input int expected, input int actual);
    if (actual != expected) begin
      failNow($sformatf("Fail %s: expected %0d, actual %0d", testName, expected, actual));
    end
  endtask

  // all ports against the model, dig expected idle
  task automatic checkAllPorts(input string testName);
    for (int d = 0; d < `SEG_NUM; d++) begin
      checkPort($sformatf("%s port %0d", testName, d), expectedPort(model[d], 1'b0), ledsd[d]);
    end
  endtask

  task automatic writeDigit(input digitIdxT idx, input digitEntryT e);
    @(posedge clk);
    wrEn   <= 1'b1;
    wrIdx  <= idx;
    wrData <= e;
    @(posedge clk); // sampled here
    wrEn <= 1'b0;
    model[idx] = e;
  endtask

  task automatic writeCfg(input logic [3:0] level, input logic enable);
    @(posedge clk);
    cfgWr   <= 1'b1;
    cfgData <= '{level: level, enable: enable};
    @(posedge clk);
    cfgWr <= 1'b0;
  endtask

  // enable edge restarts at digit 0 slot 0; returns one cycle later, lined up with digEn
  task automatic restartScan(input logic [3:0] level);
    writeCfg(level, 1'b0);
    writeCfg(level, 1'b1);
    @(posedge clk);
  endtask

  task automatic countActive(input int cycles);
    for (int d = 0; d < `SEG_NUM; d++) begin
      activeCnt[d] = 0;
    end
    repeat (cycles) begin
      @(negedge clk); // outputs settled
      for (int d = 0; d < `SEG_NUM; d++) begin
        if ((ledsd[d].dig ^ comLvl) == 1'b1) begin
          activeCnt[d]++;
        end
      end
    end
  endtask

  task automatic resetState();
    @(negedge clk);
    checkAllPorts("reset");
  endtask

  task automatic decodeAll();
    digitIdxT   idx;
    digitEntryT e;
    for (int c = 0; c < 32; c++) begin
      idx = digitIdxT'(drawBits($bits(digitIdxT)));
      e = '{code: 5'(c), dp: 1'(drawBits(1)), blink: 1'b0};
      writeDigit(idx, e);
      @(negedge clk);
      checkAllPorts($sformatf("decode code %0d", c));
    end
  endtask

  task automatic fullScan();
    restartScan(4'd15);
    countActive(4 * roundCycles);
    for (int d = 0; d < `SEG_NUM; d++) begin
      checkCount($sformatf("full scan digit %0d", d), 4 * 15, activeCnt[d]);
    end
  endtask

  task automatic brightnessSweep();
    logic [3:0] lvl;
    for (int t = 0; t < 5; t++) begin
      lvl = (t == 0) ? 4'd0 : 4'(drawBits(4)); // level 0 always covered
      restartScan(lvl);
      countActive(roundCycles);
      for (int d = 0; d < `SEG_NUM; d++) begin
        checkCount($sformatf("brightness %0d digit %0d", lvl, d), int'(lvl), activeCnt[d]);
      end
    end
  endtask

  task automatic blinkHalf();
    digitIdxT   bIdx;
    digitEntryT e;
    bIdx = digitIdxT'(drawBits($bits(digitIdxT)));
    e = model[bIdx];
    e.blink = 1'b1;
    writeDigit(bIdx, e);
    restartScan(4'd15);
    countActive(blinkRounds * roundCycles);
    for (int d = 0; d < `SEG_NUM; d++) begin
      if (d == int'(bIdx)) begin
        // lit only during the on half
        checkCount($sformatf("blink digit %0d", d), blinkRounds * 15 / 2, activeCnt[d]);
      end else begin
        checkCount($sformatf("steady digit %0d", d), blinkRounds * 15, activeCnt[d]);
      end
    end
    e.blink = 1'b0;
    writeDigit(bIdx, e);
  endtask

  task automatic disableScan();
    digitIdxT   idx;
    digitEntryT e;
    writeCfg(4'd15, 1'b0);
    @(posedge clk); // last registered enable drains
    countActive(roundCycles);
    for (int d = 0; d < `SEG_NUM; d++) begin
      checkCount($sformatf("disable digit %0d", d), 0, activeCnt[d]);
    end
    idx = digitIdxT'(drawBits($bits(digitIdxT)));
    e = '{code: 5'(drawBits(5)), dp: 1'(drawBits(1)), blink: 1'b0};
    writeDigit(idx, e);
    @(negedge clk);
    checkAllPorts("disable write");
  endtask

  // watchdog
  initial begin
    repeat (budgetCycles) @(posedge clk);
    failNow($sformatf("timeout, run exceeded %0d cycles", budgetCycles));
  end

  initial begin
    lfsrState = 32'hdd50;
    arstN   = 1'b0;
    wrEn    = 1'b0;
    wrIdx   = '0;
    wrData  = '0;
    cfgWr   = 1'b0;
    cfgData = '0;
    for (int d = 0; d < `SEG_NUM; d++) begin
      model[d] = '0; // reset contents
    end
    repeat (2) @(posedge clk);
    arstN <= 1'b1;
    resetState();
    decodeAll();
    fullScan();
    brightnessSweep();
    blinkHalf();
    disableScan();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: segDisplayTop.f
+incdir+hw
hw/segDisplay_pkg.sv
hw/strobeBank.sv
hw/scanCtrl.sv
hw/brightPwm.sv
hw/segDecoder.sv
hw/segDisplayTop.sv
tb/tbClock.sv
tb/segDisplay_properties.sv
tb/segDisplayTb.sv

// File: run.sh
#!/bin/sh
# build and run the segDisplay testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module segDisplayTb \
  -f segDisplayTop.f \
  -o segDisplaySim

# simulator status is not trusted, the log decides
./obj_dir/segDisplaySim | tee sim.log || true

if grep -q "All tests passed!" sim.log; then
  echo "simulation PASSED"
  exit 0
else
  echo "simulation FAILED, see sim.log"
  exit 1
fi
